// ==== pit_pkg.sv ====
// ##########################################################
// Shared types of the programmable interval timer covering
// control word views, counter modes, access formats and
// counter commands
// ##########################################################

`default_nettype none

package pit_pkg;

    // Control register sits above the three counter addresses
    localparam logic [1:0] ctrl_addr = 2'd3;

    // Supported counting modes as encoded in the control word
    typedef enum logic [2:0] {
        pit_mode_0 = 3'd0,
        pit_mode_2 = 3'd2,
        pit_mode_3 = 3'd3
    } pit_mode_e;

    // Access format with zero marking a counter latch command
    typedef enum logic [1:0] {
        pit_rw_latch   = 2'd0,
        pit_rw_lsb     = 2'd1,
        pit_rw_msb     = 2'd2,
        pit_rw_lsb_msb = 2'd3
    } pit_rw_e;

    // Mode command view. Mode field kept raw since 6 and 7 alias 2 and 3
    typedef struct packed {
        logic [1:0] sel;
        pit_rw_e    rw;
        logic [2:0] mode;
        logic       bcd;
    } pit_mode_fields_t;

    // Latch command view
    typedef struct packed {
        logic [1:0] sel;
        pit_rw_e    rw;
        logic [3:0] dont_care;
    } pit_latch_fields_t;

    typedef union packed {
        pit_mode_fields_t  mode_view;
        pit_latch_fields_t latch_view;
    } pit_ctrl_word_u;

    // Strobes in each per-counter command are single-cycle pulses
    typedef struct packed {
        logic           ctrl_valid;
        logic           data_valid;
        logic           latch_valid;
        logic           read_done;
        pit_ctrl_word_u ctrl;
        logic [7:0]     data;
    } pit_cmd_t;

endpackage

`default_nettype wire

// ==== pit_bus_if.sv ====
// ##########################################################
// Bus interface that samples the strobe bus, detects access
// edges and turns writes and read ends into counter commands
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module pit_bus_if import pit_pkg::*; #(
    parameter int unsigned num_counters = 3
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       chip_select_n,
    input  logic       read_enable_n,
    input  logic       write_enable_n,
    input  logic [1:0] address,
    input  logic [7:0] data_in,
    output pit_cmd_t   cmd [num_counters],
    output logic       read_active
);

    logic           write_access;
    logic           write_q;
    logic           write_prev;
    logic           read_q;
    logic           read_prev;
    logic [1:0]     address_q;
    logic [7:0]     data_q;
    logic           write_start;
    logic           read_end;
    pit_ctrl_word_u ctrl_word;
    logic           ctrl_is_latch;
    logic [1:0]     ctrl_select;
    pit_cmd_t       cmd_next [num_counters];

    assign write_access = ~chip_select_n & ~write_enable_n;
    assign read_active  = ~chip_select_n & ~read_enable_n & write_enable_n;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            write_q    <= 1'b0;
            write_prev <= 1'b0;
            read_q     <= 1'b0;
            read_prev  <= 1'b0;
        end else begin
            write_q    <= write_access;
            write_prev <= write_q;
            read_q     <= read_active;
            read_prev  <= read_q;
        end
    end

    // Address and data follow the bus only during an access,
    // so the address is still known when a read ends
    always_ff @(posedge clock) begin
        if (write_access || read_active) begin
            address_q <= address;
            data_q    <= data_in;
        end
    end

    assign write_start = write_q & ~write_prev;
    assign read_end    = ~read_q & read_prev;

    // Same byte decoded two ways
    assign ctrl_word     = data_q;
    assign ctrl_is_latch = (ctrl_word.latch_view.rw == pit_rw_latch);
    // Select field occupies the same bits in both views
    assign ctrl_select   = ctrl_word.mode_view.sel;

    always_comb begin
        for (int i = 0; i < num_counters; i++) begin
            cmd_next[i]      = '0;
            cmd_next[i].ctrl = ctrl_word;
            cmd_next[i].data = data_q;
            if (write_start) begin
                if (address_q == ctrl_addr) begin
                    // Select values past the last counter match nothing
                    if (ctrl_select == 2'(i)) begin
                        cmd_next[i].latch_valid = ctrl_is_latch;
                        cmd_next[i].ctrl_valid  = ~ctrl_is_latch;
                    end
                end else if (address_q == 2'(i)) begin
                    cmd_next[i].data_valid = 1'b1;
                end
            end
            if (read_end && address_q == 2'(i)) begin
                cmd_next[i].read_done = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_counters; i++) begin
                cmd[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_counters; i++) begin
                cmd[i] <= cmd_next[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== pit_input_sync.sv ====
// ##########################################################
// Counter input synchronizer with two flops on every count
// clock and gate and a rising-edge pulse on the count clocks
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module pit_input_sync #(
    parameter int unsigned num_counters = 3
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [num_counters-1:0] counter_clock,
    input  logic [num_counters-1:0] counter_gate,
    output logic [num_counters-1:0] count_pulse,
    output logic [num_counters-1:0] gate_sync
);

    logic [num_counters-1:0] clock_meta;
    logic [num_counters-1:0] clock_sync;
    logic [num_counters-1:0] clock_prev;
    logic [num_counters-1:0] gate_meta;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            clock_meta  <= '0;
            clock_sync  <= '0;
            clock_prev  <= '0;
            count_pulse <= '0;
            gate_meta   <= '0;
            gate_sync   <= '0;
        end else begin
            clock_meta <= counter_clock;
            clock_sync <= clock_meta;
            clock_prev <= clock_sync;
            // Registered edge pulse lands three clocks after the pin
            count_pulse <= clock_sync & ~clock_prev;
            gate_meta   <= counter_gate;
            gate_sync   <= gate_meta;
        end
    end

endmodule

`default_nettype wire

// ==== pit_counter.sv ====
// ##########################################################
// One 16-bit down counter with modes 0, 2 and 3, count
// loading, output latch and byte sequencing for bus access
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module pit_counter import pit_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  pit_cmd_t   cmd,
    input  logic       count_pulse,
    input  logic       gate,
    output logic       out,
    output logic [7:0] read_byte
);

    pit_mode_e   mode;
    pit_mode_e   new_mode;
    pit_rw_e     rw;
    logic        running;
    logic        count_ready;
    logic        write_msb_next;
    logic        read_msb_next;
    logic        latched;
    logic [15:0] pending;
    logic [15:0] reload;
    logic [15:0] count;
    logic [15:0] latch;
    logic [15:0] count_next;
    logic [15:0] read_value;
    logic        write_done;
    logic        load_now;
    logic        step_now;
    logic        terminal;

    // Codes 6 and 7 alias modes 2 and 3; unsupported modes run as mode 0
    always_comb begin
        case (cmd.ctrl.mode_view.mode[1:0])
            2'b10:   new_mode = pit_mode_2;
            2'b11:   new_mode = pit_mode_3;
            default: new_mode = pit_mode_0;
        endcase
    end

    assign write_done = cmd.data_valid & ((rw != pit_rw_lsb_msb) | write_msb_next);
    assign load_now   = count_pulse & gate & count_ready;
    assign step_now   = count_pulse & gate & running & ~count_ready;

    always_comb begin
        terminal   = 1'b0;
        count_next = count - 16'd1;
        case (mode)
            pit_mode_2: begin
                terminal = (count == 16'd1);
                if (terminal) begin
                    count_next = reload;
                end
            end
            pit_mode_3: begin
                // Odd counts drop by one first, so the high half is one longer
                terminal = (count == 16'd2);
                if (terminal) begin
                    count_next = out ? {reload[15:1], 1'b0} : reload;
                end else if (!count[0]) begin
                    count_next = count - 16'd2;
                end
            end
            default: terminal = (count == 16'd1);
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mode           <= pit_mode_0;
            rw             <= pit_rw_lsb;
            out            <= 1'b1;
            running        <= 1'b0;
            count_ready    <= 1'b0;
            write_msb_next <= 1'b0;
            read_msb_next  <= 1'b0;
            latched        <= 1'b0;
        end else if (cmd.ctrl_valid) begin
            mode           <= new_mode;
            rw             <= cmd.ctrl.mode_view.rw;
            out            <= (new_mode != pit_mode_0);
            running        <= 1'b0;
            count_ready    <= 1'b0;
            write_msb_next <= 1'b0;
            read_msb_next  <= 1'b0;
            latched        <= 1'b0;
        end else begin
            if (load_now) begin
                count_ready <= 1'b0;
                running     <= 1'b1;
                out         <= (mode != pit_mode_0);
            end else if (step_now) begin
                case (mode)
                    pit_mode_2: begin
                        if (terminal) begin
                            out <= 1'b1;
                        end else if (count == 16'd2) begin
                            out <= 1'b0;
                        end
                    end
                    pit_mode_3: begin
                        if (terminal) begin
                            out <= ~out;
                        end
                    end
                    default: begin
                        if (terminal) begin
                            out <= 1'b1;
                        end
                    end
                endcase
            end
            // A completed write queues the count for the next pulse
            if (cmd.data_valid && rw == pit_rw_lsb_msb) begin
                write_msb_next <= ~write_msb_next;
            end
            if (write_done) begin
                count_ready <= 1'b1;
            end
            if (cmd.latch_valid && !latched) begin
                latched       <= 1'b1;
                read_msb_next <= 1'b0;
            end
            // Latch releases once its last byte has been read
            if (cmd.read_done) begin
                if (rw == pit_rw_lsb_msb) begin
                    read_msb_next <= ~read_msb_next;
                    if (read_msb_next) begin
                        latched <= 1'b0;
                    end
                end else begin
                    latched <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (cmd.data_valid) begin
            case (rw)
                pit_rw_msb: pending <= {cmd.data, 8'h00};
                pit_rw_lsb_msb: begin
                    if (write_msb_next) begin
                        pending[15:8] <= cmd.data;
                    end else begin
                        pending[7:0] <= cmd.data;
                    end
                end
                default: pending <= {8'h00, cmd.data};
            endcase
        end
        if (load_now) begin
            count  <= pending;
            reload <= pending;
        end else if (step_now) begin
            count <= count_next;
        end
        if (cmd.latch_valid && !latched) begin
            latch <= count;
        end
    end

    assign read_value = latched ? latch : count;

    always_comb begin
        case (rw)
            pit_rw_msb:     read_byte = read_value[15:8];
            pit_rw_lsb_msb: read_byte = read_msb_next ? read_value[15:8] : read_value[7:0];
            default:        read_byte = read_value[7:0];
        endcase
    end

endmodule

`default_nettype wire

// ==== pit_read_mux.sv ====
// ##########################################################
// Read data mux that picks the addressed counter's byte and
// drives the data output enable during a read
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module pit_read_mux #(
    parameter int unsigned num_counters = 3
) (
    input  logic [7:0] read_byte [num_counters],
    input  logic [1:0] address,
    input  logic       read_active,
    output logic [7:0] data_out,
    output logic       data_out_enable
);

    logic [7:0] selected;

    // Control address and missing counters read as zero
    always_comb begin
        selected = 8'h00;
        for (int i = 0; i < num_counters; i++) begin
            if (address == 2'(i)) begin
                selected = read_byte[i];
            end
        end
    end

    // Bus stays quiet outside a read
    assign data_out        = read_active ? selected : 8'h00;
    assign data_out_enable = read_active;

endmodule

`default_nettype wire

// ==== pit_top.sv ====
// ##########################################################
// Programmable interval timer top joining the bus interface,
// input synchronizer, counter array and read data mux
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module pit_top import pit_pkg::*; #(
    parameter int unsigned num_counters = 3
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    chip_select_n,
    input  logic                    read_enable_n,
    input  logic                    write_enable_n,
    input  logic [1:0]              address,
    input  logic [7:0]              data_in,
    input  logic [num_counters-1:0] clock_in,
    input  logic [num_counters-1:0] gate_in,
    output logic [7:0]              data_out,
    output logic                    data_out_enable,
    output logic [num_counters-1:0] out
);

    pit_cmd_t                cmd [num_counters];
    logic [7:0]              read_byte [num_counters];
    logic [num_counters-1:0] count_pulse;
    logic [num_counters-1:0] gate_sync;
    logic                    read_active;

    pit_bus_if #(.num_counters(num_counters)) pit_bus_if_i (
        .clock          (clock),
        .reset          (reset),
        .chip_select_n  (chip_select_n),
        .read_enable_n  (read_enable_n),
        .write_enable_n (write_enable_n),
        .address        (address),
        .data_in        (data_in),
        .cmd            (cmd),
        .read_active    (read_active)
    );

    pit_input_sync #(.num_counters(num_counters)) pit_input_sync_i (
        .clock         (clock),
        .reset         (reset),
        .counter_clock (clock_in),
        .counter_gate  (gate_in),
        .count_pulse   (count_pulse),
        .gate_sync     (gate_sync)
    );

    for (genvar i = 0; i < num_counters; i++) begin : gen_counter
        pit_counter pit_counter_i (
            .clock       (clock),
            .reset       (reset),
            .cmd         (cmd[i]),
            .count_pulse (count_pulse[i]),
            .gate        (gate_sync[i]),
            .out         (out[i]),
            .read_byte   (read_byte[i])
        );
    end

    pit_read_mux #(.num_counters(num_counters)) pit_read_mux_i (
        .read_byte       (read_byte),
        .address         (address),
        .read_active     (read_active),
        .data_out        (data_out),
        .data_out_enable (data_out_enable)
    );

endmodule

`default_nettype wire

// ==== pit_assert.sv ====
// ##########################################################
// Bus and output checks for the interval timer top level
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module pit_assert import pit_pkg::*; #(
    parameter int unsigned num_counters = 3
) (
    input logic                    clock,
    input logic                    reset,
    input logic                    chip_select_n,
    input logic                    read_enable_n,
    input logic                    data_out_enable,
    input pit_cmd_t                cmd [num_counters],
    input logic [num_counters-1:0] out
);

    // Data output only driven during a read
    enable_in_read: assert property (@(posedge clock) disable iff (reset)
        data_out_enable |-> (!chip_select_n && !read_enable_n))
        else $error("data_out_enable high outside a read access");

    for (genvar i = 0; i < num_counters; i++) begin : gen_strobe_checks
        logic [3:0] strobes;
        assign strobes = {cmd[i].ctrl_valid, cmd[i].data_valid,
                          cmd[i].latch_valid, cmd[i].read_done};
        single_pulse: assert property (@(posedge clock) disable iff (reset)
            (strobes & $past(strobes)) == 4'd0)
            else $error("command strobe of counter %0d held longer than one cycle", i);
    end

    out_known: assert property (@(posedge clock) disable iff (reset) !$isunknown(out))
        else $error("counter output unknown after reset");

endmodule

bind pit_top pit_assert #(.num_counters(num_counters)) pit_assert_i (
    .clock           (clock),
    .reset           (reset),
    .chip_select_n   (chip_select_n),
    .read_enable_n   (read_enable_n),
    .data_out_enable (data_out_enable),
    .cmd             (cmd),
    .out             (out)
);

`default_nettype wire

// ==== pit_tb.sv ====
// ##########################################################
// Testbench for the interval timer with random bus
// programming and count clock stimulus checked against a
// per-counter model
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module pit_tb import pit_pkg::*; ;

    logic       clock;
    logic       reset;
    logic       chip_select_n;
    logic       read_enable_n;
    logic       write_enable_n;
    logic [1:0] address;
    logic [7:0] data_in;
    logic [2:0] clock_in;
    logic [2:0] gate_in;
    logic [7:0] data_out;
    logic       data_out_enable;
    logic [2:0] out;

    // Counter model state with one entry per counter
    logic [2:0]  model_mode [3];
    logic [1:0]  model_rw [3];
    logic        model_out [3];
    logic        model_running [3];
    logic        model_ready [3];
    logic        model_latched [3];
    logic        model_read_msb [3];
    logic [15:0] model_pending [3];
    logic [15:0] model_count [3];
    logic [15:0] model_reload [3];
    logic [15:0] model_latch [3];

    pit_top #(.num_counters(3)) pit_top_i (
        .clock           (clock),
        .reset           (reset),
        .chip_select_n   (chip_select_n),
        .read_enable_n   (read_enable_n),
        .write_enable_n  (write_enable_n),
        .address         (address),
        .data_in         (data_in),
        .clock_in        (clock_in),
        .gate_in         (gate_in),
        .data_out        (data_out),
        .data_out_enable (data_out_enable),
        .out             (out)
    );

    always #20 clock = ~clock;

    task automatic fail_value(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
        $display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
        $display("test failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout: %s", what);
        $display("test failed");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic bus_write(input logic [1:0] addr, input logic [7:0] data);
        @(negedge clock);
        chip_select_n  = 1'b0;
        write_enable_n = 1'b0;
        address        = addr;
        data_in        = data;
        repeat (3) @(negedge clock);
        chip_select_n  = 1'b1;
        write_enable_n = 1'b1;
        repeat (3) @(negedge clock);
    endtask

    // Control write puts out at its mode's initial level and waits for a count
    task automatic program_mode(input int idx, input logic [1:0] rw, input logic [2:0] mode);
        bus_write(ctrl_addr, {2'(idx), rw, mode, 1'b0});
        model_mode[idx]     = mode;
        model_rw[idx]       = rw;
        model_out[idx]      = (mode != 3'd0);
        model_running[idx]  = 1'b0;
        model_ready[idx]    = 1'b0;
        model_latched[idx]  = 1'b0;
        model_read_msb[idx] = 1'b0;
    endtask

    task automatic load_count(input int idx, input logic [15:0] value);
        case (model_rw[idx])
            2'd1: begin
                bus_write(2'(idx), value[7:0]);
                model_pending[idx] = {8'h00, value[7:0]};
            end
            2'd2: begin
                bus_write(2'(idx), value[15:8]);
                model_pending[idx] = {value[15:8], 8'h00};
            end
            default: begin
                bus_write(2'(idx), value[7:0]);
                bus_write(2'(idx), value[15:8]);
                model_pending[idx] = value;
            end
        endcase
        model_ready[idx] = 1'b1;
    endtask

    task automatic latch_count(input int idx);
        bus_write(ctrl_addr, {2'(idx), 6'b000000});
        if (!model_latched[idx]) begin
            model_latched[idx]  = 1'b1;
            model_latch[idx]    = model_count[idx];
            model_read_msb[idx] = 1'b0;
        end
    endtask

    task automatic read_and_check(input int idx);
        logic [15:0] value;
        logic [7:0]  expected;
        int          wait_count;
        value = model_latched[idx] ? model_latch[idx] : model_count[idx];
        case (model_rw[idx])
            2'd2:    expected = value[15:8];
            2'd3:    expected = model_read_msb[idx] ? value[15:8] : value[7:0];
            default: expected = value[7:0];
        endcase
        @(negedge clock);
        chip_select_n = 1'b0;
        read_enable_n = 1'b0;
        address       = 2'(idx);
        wait_count    = 0;
        do begin
            @(negedge clock);
            wait_count++;
        end while (!data_out_enable && wait_count < 8);
        assert (data_out_enable) else fail_timeout("data_out_enable never rose during a read");
        repeat (2) @(negedge clock);
        assert (data_out === expected)
            else fail_value($sformatf("data_out of counter %0d", idx), 16'(data_out),
                            16'(expected));
        chip_select_n = 1'b1;
        read_enable_n = 1'b1;
        // Latch holds until its last byte is read
        if (model_rw[idx] == 2'd3) begin
            if (model_read_msb[idx]) begin
                model_latched[idx] = 1'b0;
            end
            model_read_msb[idx] = !model_read_msb[idx];
        end else begin
            model_latched[idx] = 1'b0;
        end
        repeat (3) @(negedge clock);
    endtask

    // One count clock rising edge
    task automatic advance_model(input int i);
        if (gate_in[i]) begin
            if (model_ready[i]) begin
                model_count[i]   = model_pending[i];
                model_reload[i]  = model_pending[i];
                model_out[i]     = (model_mode[i] != 3'd0);
                model_ready[i]   = 1'b0;
                model_running[i] = 1'b1;
            end else if (model_running[i]) begin
                case (model_mode[i])
                    3'd2: begin
                        if (model_count[i] == 16'd1) begin
                            model_count[i] = model_reload[i];
                            model_out[i]   = 1'b1;
                        end else begin
                            model_count[i] = model_count[i] - 16'd1;
                            model_out[i]   = (model_count[i] != 16'd1);
                        end
                    end
                    3'd3: begin
                        // Low half starts from the even part of the count
                        if (model_count[i] == 16'd2) begin
                            model_out[i]   = !model_out[i];
                            model_count[i] = model_out[i] ? model_reload[i]
                                                          : (model_reload[i] & 16'hfffe);
                        end else begin
                            model_count[i] = model_count[i] - (model_count[i][0] ? 16'd1 : 16'd2);
                        end
                    end
                    default: begin
                        model_count[i] = model_count[i] - 16'd1;
                        if (model_count[i] == 16'd0) begin
                            model_out[i] = 1'b1;
                        end
                    end
                endcase
            end
        end
    endtask

    task automatic check_outputs();
        for (int i = 0; i < 3; i++) begin
            assert (out[i] === model_out[i])
                else fail_value($sformatf("out[%0d]", i), 16'(out[i]), 16'(model_out[i]));
        end
        assert (!data_out_enable) else fail_value("data_out_enable", 16'(data_out_enable), 16'd0);
    endtask

    task automatic run_count_clocks(input int n);
        repeat (n) begin
            @(negedge clock);
            clock_in = '1;
            repeat (4) @(negedge clock);
            clock_in = '0;
            repeat (4) @(negedge clock);
            for (int i = 0; i < 3; i++) begin
                advance_model(i);
            end
            check_outputs();
        end
    endtask

    // Square wave half periods measured on the pin
    task automatic check_square(input int idx, input int n);
        int high_len;
        int low_len;
        program_mode(idx, 2'd1, 3'd3);
        load_count(idx, 16'(n));
        run_count_clocks(1);
        high_len = 0;
        low_len  = 0;
        while (out[idx] && high_len <= n) begin
            run_count_clocks(1);
            high_len++;
        end
        while (!out[idx] && low_len <= n) begin
            run_count_clocks(1);
            low_len++;
        end
        // Even counts split evenly, odd counts give the extra pulse to the high half
        assert (high_len == (n + 1) / 2)
            else fail_value("out high half", 16'(high_len), 16'((n + 1) / 2));
        assert (low_len == n / 2)
            else fail_value("out low half", 16'(low_len), 16'(n / 2));
    endtask

    initial begin
        int         n;
        logic [2:0] mode_pick;
        void'($urandom(32'h7826));
        clock          = 1'b0;
        reset          = 1'b1;
        chip_select_n  = 1'b1;
        read_enable_n  = 1'b1;
        write_enable_n = 1'b1;
        address        = 2'd0;
        data_in        = 8'h00;
        clock_in       = '0;
        gate_in        = '1;
        for (int i = 0; i < 3; i++) begin
            model_mode[i]     = 3'd0;
            model_rw[i]       = 2'd1;
            model_out[i]      = 1'b1;
            model_running[i]  = 1'b0;
            model_ready[i]    = 1'b0;
            model_latched[i]  = 1'b0;
            model_read_msb[i] = 1'b0;
            model_count[i]    = 16'd0;
        end
        repeat (8) @(negedge clock);
        reset = 1'b0;
        run_count_clocks(2);

        // Mode 0 single shot
        n = $urandom_range(40, 2);
        program_mode(0, 2'd1, 3'd0);
        check_outputs();
        load_count(0, 16'(n));
        run_count_clocks(n + 4);

        // Rate generator followed by even and odd square waves
        n = $urandom_range(40, 2);
        program_mode(1, 2'd1, 3'd2);
        load_count(1, 16'(n));
        run_count_clocks(3 * n + 2);
        check_square(2, 2 * $urandom_range(20, 1));
        check_square(2, 2 * $urandom_range(20, 1) + 1);

        // Gate held low freezes the count
        program_mode(0, 2'd1, 3'd2);
        load_count(0, 16'($urandom_range(40, 5)));
        run_count_clocks(3);
        gate_in[0] = 1'b0;
        read_and_check(0);
        run_count_clocks($urandom_range(12, 3));
        read_and_check(0);
        gate_in[0] = 1'b1;
        run_count_clocks(6);
        read_and_check(0);

        // Latch mid count and then live bytes
        program_mode(1, 2'd3, 3'd0);
        load_count(1, 16'($urandom_range(2000, 300)));
        run_count_clocks($urandom_range(10, 3));
        latch_count(1);
        run_count_clocks(3);
        read_and_check(1);
        run_count_clocks(2);
        read_and_check(1);
        read_and_check(1);
        read_and_check(1);

        // All counters at once with random setup
        for (int i = 0; i < 3; i++) begin
            case ($urandom_range(2, 0))
                0:       mode_pick = 3'd0;
                1:       mode_pick = 3'd2;
                default: mode_pick = 3'd3;
            endcase
            program_mode(i, 2'($urandom_range(3, 1)), mode_pick);
            load_count(i, 16'($urandom_range(40, 2)));
        end
        run_count_clocks(1);
        repeat (80) begin
            run_count_clocks(1);
            if ($urandom_range(3, 0) == 0) begin
                read_and_check($urandom_range(2, 0));
            end
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
pit_pkg.sv
pit_bus_if.sv
pit_input_sync.sv
pit_counter.sv
pit_read_mux.sv
pit_top.sv
pit_assert.sv
pit_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module pit_tb -o pit_sim

sim_output=$(./obj_dir/pit_sim || true)
echo "$sim_output"

if echo "$sim_output" | grep -qx "test passed"; then
    exit 0
else
    exit 1
fi
